// ==== design/fmaUnit_params.svh ====
`ifndef FMA_UNIT_PARAMS_SVH
`define FMA_UNIT_PARAMS_SVH

// ############################################################
// datapath sizes, fp16 fraction plus hidden bit.
// ############################################################
`define FP16_FRACW 10
`define FMA_WIDTH (`FP16_FRACW + 1)
`define FMA_OUTWIDTH (2 * `FMA_WIDTH)
`define MUL_ITERS ((`FMA_WIDTH + 3) / 4)  // radix-16 digits per operand.

// ############################################################
// host bus.
// ############################################################
`define AXI_ADDRW 8
`define AXI_DATAW 32

`endif

// ==== design/fmaPkg.sv ====
`include "fmaUnit_params.svh"

package fmaPkg;

  typedef enum logic [1:0] {
    OP_MADD  = 2'b00,  // product + addend.
    OP_MSUB  = 2'b01,  // product - addend.
    OP_NMADD = 2'b10,  // -product + addend.
    OP_NMSUB = 2'b11   // -product - addend.
  } fmaOp_t;

  typedef enum logic [2:0] {
    FMAD_WAIT,
    FMAD_MUL_KICK,
    FMAD_MUL,
    FMAD_ADD,
    FMAD_DONE
  } fmadState_t;

  typedef struct packed {
    logic [`FMA_WIDTH-1:0] mulIn1;
    logic [`FMA_WIDTH-1:0] mulIn2;
    logic [`FMA_WIDTH-1:0] addIn;
    fmaOp_t                op;
  } fmaReq_t;

  typedef struct packed {
    logic [`FMA_OUTWIDTH-1:0] value;  // two's complement, wraps modulo 2^22.
  } fmaResult_t;

  typedef struct packed {
    logic                  awvalid;
    logic [`AXI_ADDRW-1:0] awaddr;
    logic                  wvalid;
    logic [`AXI_DATAW-1:0] wdata;
    logic                  bready;
    logic                  arvalid;
    logic [`AXI_ADDRW-1:0] araddr;
    logic                  rready;
  } axiLiteReq_t;

  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [`AXI_DATAW-1:0] rdata;
    logic [1:0]            rresp;
  } axiLiteRsp_t;

endpackage

// ==== design/radix16Mult.sv ====
`timescale 1ns/1ns
`include "fmaUnit_params.svh"

module radix16Mult #(
  parameter int WIDTH = `FMA_WIDTH
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [WIDTH-1:0]     mulIn1,
  input  logic [WIDTH-1:0]     mulIn2,
  input  logic                 start,
  output logic [2*WIDTH-1:0]   mulOut,
  output logic                 done
);

  localparam int ITERS = (WIDTH + 3) / 4;
  localparam int MPW   = 4 * ITERS;
  localparam int CNTW  = $clog2(ITERS + 1);
  localparam int OUTW  = 2 * WIDTH;

  logic              active;
  logic [CNTW-1:0]   iter;
  logic [OUTW-1:0]   mcand;
  logic [MPW-1:0]    mplier;
  logic [OUTW-1:0]   partial;

  // multiplicand times the current hex digit, already shifted into place.
  assign partial = mcand * OUTW'(mplier[3:0]);

  // done marks the last digit cycle, the product settles on that edge.
  assign done = active && (iter == CNTW'(ITERS - 1));

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      active <= 1'b0;
      iter   <= '0;
    end else if (start) begin
      active <= 1'b1;
      iter   <= '0;
    end else if (active) begin
      active <= !done;
      iter   <= iter + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      mcand  <= OUTW'(mulIn1);
      mplier <= MPW'(mulIn2);
      mulOut <= '0;
    end else if (active) begin
      mulOut <= mulOut + partial;
      mcand  <= mcand << 4;
      mplier <= mplier >> 4;
    end
  end

endmodule

// ==== design/fmad.sv ====
`timescale 1ns/1ns
`include "fmaUnit_params.svh"

module fmad import fmaPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        start,
  input  fmaReq_t     req,
  output fmaResult_t  result,
  output logic        resultValid,
  output logic        busy
);

  fmaReq_t                  latched;
  logic                     mulStart;
  logic                     mulDone;
  logic                     addEn;
  logic                     negate;
  logic                     sub;
  logic [`FMA_OUTWIDTH-1:0] mulOut;
  logic [`FMA_OUTWIDTH-1:0] product;
  logic [`FMA_OUTWIDTH-1:0] addend;

  // a start seen while busy is dropped here.
  always_ff @(posedge clock) begin
    if (start && !busy) begin
      latched <= req;
    end
  end

  always_comb begin
    case (latched.op)
      OP_MADD:  {negate, sub} = 2'b00;
      OP_MSUB:  {negate, sub} = 2'b01;
      OP_NMADD: {negate, sub} = 2'b10;
      default:  {negate, sub} = 2'b11;
    endcase
  end

  assign product = negate ? -mulOut : mulOut;
  assign addend  = `FMA_OUTWIDTH'(latched.addIn);

  always_ff @(posedge clock) begin
    if (addEn) begin
      result.value <= sub ? product - addend : product + addend;
    end
  end

  radix16Mult #(.WIDTH(`FMA_WIDTH)) u_mult (
    .clock,
    .reset,
    .mulIn1 (latched.mulIn1),
    .mulIn2 (latched.mulIn2),
    .start  (mulStart),
    .mulOut,
    .done   (mulDone)
  );

  fmadFsm u_fsm (
    .clock,
    .reset,
    .start,
    .mulDone,
    .mulStart,
    .addEn,
    .resultValid,
    .busy
  );

endmodule

module fmadFsm import fmaPkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic mulDone,
  output logic mulStart,
  output logic addEn,
  output logic resultValid,
  output logic busy
);

  fmadState_t state;
  fmadState_t nextState;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= FMAD_WAIT;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      FMAD_WAIT:     nextState = start ? FMAD_MUL_KICK : FMAD_WAIT;
      FMAD_MUL_KICK: nextState = FMAD_MUL;
      FMAD_MUL:      nextState = mulDone ? FMAD_ADD : FMAD_MUL;
      FMAD_ADD:      nextState = FMAD_DONE;
      FMAD_DONE:     nextState = start ? FMAD_MUL_KICK : FMAD_WAIT;  // back-to-back allowed.
      default:       nextState = FMAD_WAIT;
    endcase
  end

  assign mulStart    = (state == FMAD_MUL_KICK);
  assign addEn       = (state == FMAD_ADD);
  assign resultValid = (state == FMAD_DONE);
  assign busy        = state inside {FMAD_MUL_KICK, FMAD_MUL, FMAD_ADD};

endmodule

// ==== design/fmaResultRegs.sv ====
`timescale 1ns/1ns

module fmaResultRegs import fmaPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         start,
  input  logic         resultValid,
  input  fmaResult_t   resultIn,
  output fmaResult_t   result,
  output logic         done,
  output logic [15:0]  opCount
);

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      done    <= 1'b0;
      opCount <= '0;
    end else begin
      if (start) begin
        done <= 1'b0;  // a new request clears the sticky flag.
      end else if (resultValid) begin
        done <= 1'b1;
      end
      if (resultValid) begin
        opCount <= opCount + 16'd1;  // wraps at 16 bits.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resultValid) begin
      result <= resultIn;
    end
  end

endmodule

// ==== design/axiLiteRegs.sv ====
`timescale 1ns/1ns
`include "fmaUnit_params.svh"

module axiLiteRegs import fmaPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  axiLiteReq_t  axiReq,
  input  logic         busy,
  input  logic         done,
  input  fmaResult_t   result,
  input  logic [15:0]  opCount,
  output axiLiteRsp_t  axiRsp,
  output logic         start,
  output fmaReq_t      req
);

  localparam logic [`AXI_ADDRW-1:0] ADDR_MUL1   = 'h00;
  localparam logic [`AXI_ADDRW-1:0] ADDR_MUL2   = 'h04;
  localparam logic [`AXI_ADDRW-1:0] ADDR_ADD    = 'h08;
  localparam logic [`AXI_ADDRW-1:0] ADDR_CTRL   = 'h0C;
  localparam logic [`AXI_ADDRW-1:0] ADDR_STATUS = 'h10;
  localparam logic [`AXI_ADDRW-1:0] ADDR_RESULT = 'h14;
  localparam logic [`AXI_ADDRW-1:0] ADDR_COUNT  = 'h18;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                  awReady;
  logic                  bValid;
  logic [1:0]            bResp;
  logic                  arReady;
  logic                  rValid;
  logic [`AXI_DATAW-1:0] rData;
  logic [1:0]            rResp;
  logic                  wrFire;
  logic                  rdFire;
  logic                  wrMapped;
  logic                  rdMapped;
  logic [`AXI_DATAW-1:0] rdMux;

  assign wrFire = awReady && axiReq.awvalid && axiReq.wvalid;
  assign rdFire = arReady && axiReq.arvalid;
  assign wrMapped = axiReq.awaddr inside {ADDR_MUL1, ADDR_MUL2, ADDR_ADD, ADDR_CTRL};

  // ############################################################
  // write channel
  // ############################################################
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      awReady <= 1'b0;
      bValid  <= 1'b0;
      start   <= 1'b0;
      req     <= '0;
    end else begin
      // address and data are taken together, one write at a time.
      awReady <= !awReady && !bValid && axiReq.awvalid && axiReq.wvalid;
      start   <= wrFire && (axiReq.awaddr == ADDR_CTRL);
      if (wrFire) begin
        bValid <= 1'b1;
      end else if (axiReq.bready) begin
        bValid <= 1'b0;
      end
      if (wrFire) begin
        case (axiReq.awaddr)
          ADDR_MUL1: req.mulIn1 <= axiReq.wdata[`FMA_WIDTH-1:0];
          ADDR_MUL2: req.mulIn2 <= axiReq.wdata[`FMA_WIDTH-1:0];
          ADDR_ADD:  req.addIn  <= axiReq.wdata[`FMA_WIDTH-1:0];
          ADDR_CTRL: req.op     <= fmaOp_t'(axiReq.wdata[1:0]);
          default:   ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wrFire) begin
      bResp <= wrMapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ############################################################
  // read channel
  // ############################################################
  always_comb begin
    rdMux    = '0;
    rdMapped = 1'b1;
    case (axiReq.araddr)
      ADDR_MUL1:   rdMux = `AXI_DATAW'(req.mulIn1);
      ADDR_MUL2:   rdMux = `AXI_DATAW'(req.mulIn2);
      ADDR_ADD:    rdMux = `AXI_DATAW'(req.addIn);
      ADDR_CTRL:   rdMux = `AXI_DATAW'(req.op);
      ADDR_STATUS: rdMux = `AXI_DATAW'({done, busy});
      ADDR_RESULT: rdMux = `AXI_DATAW'(result.value);
      ADDR_COUNT:  rdMux = `AXI_DATAW'(opCount);
      default:     rdMapped = 1'b0;
    endcase
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      arReady <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      arReady <= !arReady && !rValid && axiReq.arvalid;
      if (rdFire) begin
        rValid <= 1'b1;
      end else if (axiReq.rready) begin
        rValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rdFire) begin
      rData <= rdMux;  // snapshot holds while rready is withheld.
      rResp <= rdMapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    axiRsp.awready = awReady;
    axiRsp.wready  = awReady;
    axiRsp.bvalid  = bValid;
    axiRsp.bresp   = bResp;
    axiRsp.arready = arReady;
    axiRsp.rvalid  = rValid;
    axiRsp.rdata   = rData;
    axiRsp.rresp   = rResp;
  end

endmodule

// ==== design/fmaTop.sv ====
`timescale 1ns/1ns

module fmaTop import fmaPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  axiLiteReq_t  axiReq,
  output axiLiteRsp_t  axiRsp
);

  logic        start;
  logic        busy;
  logic        resultValid;
  logic        done;
  logic [15:0] opCount;
  fmaReq_t     req;
  fmaResult_t  coreResult;
  fmaResult_t  heldResult;

  // ############################################################
  // host side, engine, result collector
  // ############################################################
  axiLiteRegs u_regs (
    .clock,
    .reset,
    .axiReq,
    .busy,
    .done,
    .result  (heldResult),
    .opCount,
    .axiRsp,
    .start,
    .req
  );

  fmad u_fmad (
    .clock,
    .reset,
    .start,
    .req,
    .result      (coreResult),
    .resultValid,
    .busy
  );

  fmaResultRegs u_results (
    .clock,
    .reset,
    .start,
    .resultValid,
    .resultIn    (coreResult),
    .result      (heldResult),
    .done,
    .opCount
  );

endmodule

// ==== dv/fmaTb.sv ====
`timescale 1ns/1ns
`include "fmaUnit_params.svh"

module fmaTb import fmaPkg::*; ();

  localparam logic [`AXI_ADDRW-1:0] REG_MUL1   = 8'h00;
  localparam logic [`AXI_ADDRW-1:0] REG_MUL2   = 8'h04;
  localparam logic [`AXI_ADDRW-1:0] REG_ADD    = 8'h08;
  localparam logic [`AXI_ADDRW-1:0] REG_CTRL   = 8'h0C;
  localparam logic [`AXI_ADDRW-1:0] REG_STATUS = 8'h10;
  localparam logic [`AXI_ADDRW-1:0] REG_RESULT = 8'h14;
  localparam logic [`AXI_ADDRW-1:0] REG_COUNT  = 8'h18;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int CORNER_OPS = 12;
  localparam int RANDOM_OPS = 40;
  localparam int NUM_OPS    = CORNER_OPS + RANDOM_OPS + 1;
  localparam int TIMEOUT_NS = (NUM_OPS * 40 + 2000) * 40;

  logic        clock;
  logic        reset;
  axiLiteReq_t axiReq;
  axiLiteRsp_t axiRsp;
  integer      seed = 32'hdd9c;
  int          opsDone = 0;
  fmaResult_t  lastExpected;

  fmaTop u_fmaTop (
    .clock,
    .reset,
    .axiReq,
    .axiRsp
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in the expected time");
    stopRun();
  end

  // ############################################################
  // failure reporting and compares
  // ############################################################
  task automatic stopRun();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkResult(input string name, input fmaResult_t got, input fmaResult_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got.value, exp.value);
      stopRun();
    end
  endtask

  task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkStatus(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stopRun();
    end
  endtask

  // opcode rule, modulo 2^22.
  function automatic fmaResult_t expectedFma(input logic [`FMA_WIDTH-1:0] a,
      input logic [`FMA_WIDTH-1:0] b, input logic [`FMA_WIDTH-1:0] c, input fmaOp_t op);
    logic [`FMA_OUTWIDTH-1:0] p;
    logic [`FMA_OUTWIDTH-1:0] z;
    fmaResult_t r;
    p = `FMA_OUTWIDTH'(a) * `FMA_OUTWIDTH'(b);
    z = `FMA_OUTWIDTH'(c);
    case (op)
      OP_MADD:  r.value = p + z;
      OP_MSUB:  r.value = p - z;
      OP_NMADD: r.value = z - p;
      default:  r.value = -p - z;
    endcase
    return r;
  endfunction

  // ############################################################
  // bus driver
  // ############################################################
  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
      output logic [1:0] resp);
    @(posedge clock);
    axiReq.awvalid <= 1'b1;
    axiReq.awaddr  <= addr;
    axiReq.wvalid  <= 1'b1;
    axiReq.wdata   <= data;
    axiReq.bready  <= 1'b1;
    do @(posedge clock); while (!axiRsp.awready);  // handshake on this edge.
    if (!axiRsp.wready) begin
      $display("wready did not rise together with awready");
      stopRun();
    end
    axiReq.awvalid <= 1'b0;
    axiReq.wvalid  <= 1'b0;
    do @(posedge clock); while (!axiRsp.bvalid);
    resp = axiRsp.bresp;
  endtask

  task automatic axiRead(input logic [7:0] addr, input int stall, output logic [31:0] data,
      output logic [1:0] resp);
    @(posedge clock);
    axiReq.arvalid <= 1'b1;
    axiReq.araddr  <= addr;
    axiReq.rready  <= (stall == 0);
    do @(posedge clock); while (!axiRsp.arready);
    axiReq.arvalid <= 1'b0;
    do @(posedge clock); while (!axiRsp.rvalid);
    data = axiRsp.rdata;
    resp = axiRsp.rresp;
    for (int i = 0; i < stall; i++) begin
      @(posedge clock);
      if (!axiRsp.rvalid) begin
        $display("rvalid dropped while rready was held low");
        stopRun();
      end
      checkData("rdata under back-pressure", axiRsp.rdata, data);
    end
    if (stall != 0) begin
      axiReq.rready <= 1'b1;
      @(posedge clock);  // transfer completes here.
    end
  endtask

  task automatic writeReadBack(input logic [7:0] addr, input logic [31:0] value);
    logic [31:0] data;
    logic [1:0]  resp;
    axiWrite(addr, value, resp);
    checkResp("bresp", resp, RESP_OKAY);
    axiRead(addr, 0, data, resp);
    checkResp("rresp", resp, RESP_OKAY);
    checkData("operand readback", data, value & 32'h7ff);
  endtask

  task automatic waitDone();
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < 20; i++) begin
      axiRead(REG_STATUS, 0, data, resp);
      if (data[1]) begin
        checkStatus("status at done", data[1:0], 2'b10);
        return;
      end
    end
    $display("the engine never reported done");
    stopRun();
  endtask

  task automatic runOp(input logic [10:0] a, input logic [10:0] b, input logic [10:0] c,
      input fmaOp_t op);
    logic [31:0] data;
    logic [1:0]  resp;
    axiWrite(REG_MUL1, 32'(a), resp);
    axiWrite(REG_MUL2, 32'(b), resp);
    axiWrite(REG_ADD, 32'(c), resp);
    axiWrite(REG_CTRL, 32'(op), resp);
    checkResp("bresp control", resp, RESP_OKAY);
    waitDone();
    lastExpected = expectedFma(a, b, c, op);
    opsDone++;
    axiRead(REG_RESULT, 0, data, resp);
    checkData("result upper bits", {data[31:`FMA_OUTWIDTH], 22'd0}, 32'd0);
    checkResult("result", fmaResult_t'(data[`FMA_OUTWIDTH-1:0]), lastExpected);
  endtask

  // ############################################################
  // directed tests
  // ############################################################
  task automatic testRegisterAccess();
    logic [31:0] data;
    logic [1:0]  resp;
    axiRead(REG_STATUS, 0, data, resp);
    checkResp("rresp status", resp, RESP_OKAY);
    checkStatus("status after reset", data[1:0], 2'b00);
    axiRead(REG_COUNT, 0, data, resp);
    checkData("count after reset", data, 32'd0);
    writeReadBack(REG_MUL1, 32'hffff_f9a5);
    writeReadBack(REG_MUL2, 32'h0000_0abc);
    writeReadBack(REG_ADD, 32'h1234_5678);
  endtask

  task automatic testCorners();
    fmaOp_t op;
    for (int k = 0; k < 4; k++) begin
      op = fmaOp_t'(k);
      runOp(11'h000, 11'h000, 11'h000, op);
      runOp(11'h7ff, 11'h7ff, 11'h7ff, op);
      runOp(11'h003, 11'h005, 11'h7ff, op);  // small product against a large addend.
    end
  endtask

  task automatic testRandom();
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      runOp(11'($random(seed)), 11'($random(seed)), 11'($random(seed)),
            fmaOp_t'(2'($random(seed))));
    end
    axiRead(REG_COUNT, 0, data, resp);
    checkData("completion count", data, 32'(opsDone));
  endtask

  task automatic testStartWhileBusy();
    logic [31:0] data;
    logic [1:0]  resp;
    logic [1:0]  resp2;
    axiWrite(REG_MUL1, 32'h0123, resp);
    axiWrite(REG_MUL2, 32'h0456, resp);
    axiWrite(REG_ADD, 32'h0789, resp);
    axiWrite(REG_CTRL, 32'(OP_MADD), resp);
    fork
      axiRead(REG_STATUS, 0, data, resp);
      axiWrite(REG_CTRL, 32'(OP_NMSUB), resp2);  // lands while the multiplier runs.
    join
    checkStatus("status while busy", data[1:0], 2'b01);
    checkResp("bresp second control", resp2, RESP_OKAY);
    waitDone();
    lastExpected = expectedFma(11'h123, 11'h456, 11'h789, OP_MADD);
    opsDone++;
    axiRead(REG_RESULT, 0, data, resp);
    checkResult("result after dropped start", fmaResult_t'(data[`FMA_OUTWIDTH-1:0]),
                lastExpected);
    axiRead(REG_COUNT, 0, data, resp);
    checkData("count after dropped start", data, 32'(opsDone));
  endtask

  task automatic testErrorsAndStall();
    logic [31:0] data;
    logic [1:0]  resp;
    axiWrite(8'h1C, 32'h0000_1234, resp);
    checkResp("bresp unmapped", resp, RESP_SLVERR);
    axiRead(8'h20, 0, data, resp);
    checkResp("rresp unmapped", resp, RESP_SLVERR);
    axiRead(REG_RESULT, 10, data, resp);
    checkResp("rresp stalled", resp, RESP_OKAY);
    checkResult("stalled result", fmaResult_t'(data[`FMA_OUTWIDTH-1:0]), lastExpected);
    writeReadBack(REG_ADD, 32'h0000_0555);
  endtask

  initial begin
    axiReq = '0;
    reset  = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    testRegisterAccess();
    testCorners();
    testRandom();
    testStartWhileBusy();
    testErrorsAndStall();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/fmaPkg.sv
design/radix16Mult.sv
design/fmad.sv
design/fmaResultRegs.sv
design/axiLiteRegs.sv
design/fmaTop.sv
dv/fmaTb.sv
